// ==== filelist.f ====
+incdir+rtl
rtl/noc_pkg.sv
rtl/axi_fifo.sv
rtl/noc_shell.sv
rtl/axi_wrapper.sv
rtl/noc_block_axi_fifo_loopback.sv
tb/noc_loopback_sva.sv
tb/tb_noc_loopback.sv

// ==== rtl/axi_fifo.sv ====
module axi_fifo #(
  parameter int WIDTH = 32,
  parameter int SIZE  = 2
) (
  input  logic             ce_clk,
  input  logic             i_rst,
  input  logic             i_clear,
  input  logic [WIDTH-1:0] i_tdata,
  input  logic             i_tvalid,
  output logic             o_tready,
  output logic [WIDTH-1:0] o_tdata,
  output logic             o_tvalid,
  input  logic             i_tready
);

  localparam int DEPTH = 1 << SIZE;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [SIZE-1:0]  wr_ptr;
  logic [SIZE-1:0]  rd_ptr;
  logic [SIZE:0]    count;
  logic             wr_en;
  logic             rd_en;

  // Full once the count reaches DEPTH, which sets its top bit
  assign o_tready = ~count[SIZE];
  assign o_tvalid = (count != '0);
  assign o_tdata  = mem[rd_ptr];

  assign wr_en = i_tvalid & o_tready;
  assign rd_en = o_tvalid & i_tready;

  always_ff @(posedge ce_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_tdata;
    end
  end

  always_ff @(posedge ce_clk) begin
    if (i_rst || i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      unique case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== rtl/axi_wrapper.sv ====
`include "noc_settings.svh"

module axi_wrapper (
  input  logic                  ce_clk,
  input  logic                  i_rst,
  input  noc_pkg::set_bus_t     i_set,
  // Packets from the shell
  input  noc_pkg::noc_stream_t  i_sink,
  input  logic                  i_sink_valid,
  output logic                  o_sink_ready,
  // Samples to the user logic
  output noc_pkg::samp_stream_t o_m,
  output logic                  o_m_valid,
  input  logic                  i_m_ready,
  // Samples from the user logic
  input  noc_pkg::samp_stream_t i_s,
  input  logic                  i_s_valid,
  output logic                  o_s_ready,
  // Packets back to the shell
  output noc_pkg::noc_stream_t  o_src,
  output logic                  o_src_valid,
  input  logic                  i_src_ready
);

  noc_pkg::df_state_e   df_state;
  noc_pkg::rf_state_e   rf_state;
  logic                 len_in_valid;
  logic                 len_in_ready;
  logic                 len_out_valid;
  logic                 len_out_ready;
  noc_pkg::pkt_len_t    len_out;
  logic                 m_xfer;
  logic                 s_xfer;
  logic                 len_pop;
  logic                 out_load;
  logic                 out_valid_r;
  noc_pkg::noc_stream_t out_r;
  noc_pkg::sample_t     lo_samp;
  noc_pkg::sid_t        next_dst;
  noc_pkg::seqnum_t     seqnum;
  noc_pkg::noc_word_t   hdr;

  //////////////////////////////
  // Deframer
  //////////////////////////////

  always_comb begin
    o_m.tdata    = i_sink.tdata[`SAMP_W-1:0];
    o_m.tlast    = 1'b0;
    o_m_valid    = 1'b0;
    o_sink_ready = 1'b0;
    len_in_valid = 1'b0;
    unique case (df_state)
      noc_pkg::DF_HEADER: begin
        // Header waits here while the length queue is full
        o_sink_ready = len_in_ready;
        len_in_valid = i_sink_valid & ~i_sink.tlast;
      end
      noc_pkg::DF_LOW: begin
        o_m_valid = i_sink_valid;
      end
      noc_pkg::DF_HIGH: begin
        o_m.tdata    = i_sink.tdata[2*`SAMP_W-1:`SAMP_W];
        o_m.tlast    = i_sink.tlast;
        o_m_valid    = i_sink_valid;
        o_sink_ready = i_m_ready;
      end
      default: ;
    endcase
  end

  assign m_xfer = o_m_valid & i_m_ready;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      df_state <= noc_pkg::DF_HEADER;
    end else begin
      unique case (df_state)
        noc_pkg::DF_HEADER: begin
          if (i_sink_valid && o_sink_ready && !i_sink.tlast) df_state <= noc_pkg::DF_LOW;
        end
        noc_pkg::DF_LOW: begin
          if (m_xfer) df_state <= noc_pkg::DF_HIGH;
        end
        noc_pkg::DF_HIGH: begin
          if (m_xfer) df_state <= i_sink.tlast ? noc_pkg::DF_HEADER : noc_pkg::DF_LOW;
        end
        default: df_state <= noc_pkg::DF_HEADER;
      endcase
    end
  end

  // Lengths of packets in flight
  axi_fifo #(
    .WIDTH(16),
    .SIZE (`LEN_FIFO_LOG2)
  ) len_fifo0 (
    .ce_clk  (ce_clk),
    .i_rst   (i_rst),
    .i_clear (1'b0),
    .i_tdata (i_sink.tdata[`HDR_LEN_MSB:`HDR_LEN_LSB]),
    .i_tvalid(len_in_valid),
    .o_tready(len_in_ready),
    .o_tdata (len_out),
    .o_tvalid(len_out_valid),
    .i_tready(len_out_ready)
  );

  //////////////////////////////
  // Reframer
  //////////////////////////////

  always_comb begin
    hdr = '0;
    hdr[`HDR_TYPE_MSB:`HDR_TYPE_LSB] = noc_pkg::DATA;
    hdr[`HDR_SEQ_MSB:`HDR_SEQ_LSB]   = seqnum;
    hdr[`HDR_LEN_MSB:`HDR_LEN_LSB]   = len_out;
    hdr[`HDR_SID_MSB:`HDR_SID_LSB]   = next_dst;
  end

  // Output register is free when empty or draining this cycle
  assign out_load      = ~out_valid_r | i_src_ready;
  assign len_out_ready = (rf_state == noc_pkg::RF_HEADER) & out_load;
  assign len_pop       = len_out_valid & len_out_ready;
  assign o_s_ready     = (rf_state == noc_pkg::RF_LOW) |
                         ((rf_state == noc_pkg::RF_HIGH) & out_load);
  assign s_xfer        = i_s_valid & o_s_ready;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      rf_state    <= noc_pkg::RF_HEADER;
      out_valid_r <= 1'b0;
      seqnum      <= '0;
      next_dst    <= '0;
    end else begin
      if (i_set.stb && (i_set.addr == noc_pkg::set_addr_t'(`SR_NEXT_DST))) begin
        next_dst <= i_set.data;
      end
      if (out_valid_r && i_src_ready) out_valid_r <= 1'b0;
      unique case (rf_state)
        noc_pkg::RF_HEADER: begin
          if (len_pop) begin
            out_valid_r <= 1'b1;
            seqnum      <= seqnum + 1'b1;
            rf_state    <= noc_pkg::RF_LOW;
          end
        end
        noc_pkg::RF_LOW: begin
          if (s_xfer) rf_state <= noc_pkg::RF_HIGH;
        end
        noc_pkg::RF_HIGH: begin
          if (s_xfer) begin
            out_valid_r <= 1'b1;
            rf_state    <= i_s.tlast ? noc_pkg::RF_HEADER : noc_pkg::RF_LOW;
          end
        end
        default: rf_state <= noc_pkg::RF_HEADER;
      endcase
    end
  end

  // Word packing, low sample first
  always_ff @(posedge ce_clk) begin
    if ((rf_state == noc_pkg::RF_LOW) && s_xfer) begin
      lo_samp <= i_s.tdata;
    end
    if (len_pop) begin
      out_r.tdata <= hdr;
      out_r.tlast <= 1'b0;
    end else if ((rf_state == noc_pkg::RF_HIGH) && s_xfer) begin
      out_r.tdata <= {i_s.tdata, lo_samp};
      out_r.tlast <= i_s.tlast;
    end
  end

  assign o_src       = out_r;
  assign o_src_valid = out_valid_r;

endmodule

// ==== rtl/noc_block_axi_fifo_loopback.sv ====
`include "noc_settings.svh"

module noc_block_axi_fifo_loopback (
  input  logic                 ce_clk,
  input  logic                 i_rst,
  input  noc_pkg::noc_stream_t i_in,
  input  logic                 i_in_valid,
  output logic                 o_in_ready,
  output noc_pkg::noc_stream_t o_out,
  output logic                 o_out_valid,
  input  logic                 i_out_ready
);

  noc_pkg::noc_stream_t  str_sink;
  logic                  str_sink_valid;
  logic                  str_sink_ready;
  noc_pkg::noc_stream_t  str_src;
  logic                  str_src_valid;
  logic                  str_src_ready;
  noc_pkg::set_bus_t     set_bus;
  noc_pkg::samp_stream_t m_axis;
  logic                  m_axis_valid;
  logic                  m_axis_ready;
  noc_pkg::samp_stream_t s_axis;
  logic                  s_axis_valid;
  logic                  s_axis_ready;

  //////////////////////////////
  // Shell
  //////////////////////////////

  noc_shell shell0 (
    .ce_clk      (ce_clk),
    .i_rst       (i_rst),
    .i_in        (i_in),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_sink      (str_sink),
    .o_sink_valid(str_sink_valid),
    .i_sink_ready(str_sink_ready),
    .i_src       (str_src),
    .i_src_valid (str_src_valid),
    .o_src_ready (str_src_ready),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .o_set       (set_bus)
  );

  //////////////////////////////
  // Wrapper
  //////////////////////////////

  axi_wrapper wrapper0 (
    .ce_clk      (ce_clk),
    .i_rst       (i_rst),
    .i_set       (set_bus),
    .i_sink      (str_sink),
    .i_sink_valid(str_sink_valid),
    .o_sink_ready(str_sink_ready),
    .o_m         (m_axis),
    .o_m_valid   (m_axis_valid),
    .i_m_ready   (m_axis_ready),
    .i_s         (s_axis),
    .i_s_valid   (s_axis_valid),
    .o_s_ready   (s_axis_ready),
    .o_src       (str_src),
    .o_src_valid (str_src_valid),
    .i_src_ready (str_src_ready)
  );

  //////////////////////////////
  // User logic
  //////////////////////////////

  // Samples loop back through a small FIFO
  axi_fifo #(
    .WIDTH($bits(noc_pkg::samp_stream_t)),
    .SIZE (`USER_FIFO_LOG2)
  ) user_fifo0 (
    .ce_clk  (ce_clk),
    .i_rst   (i_rst),
    .i_clear (1'b0),
    .i_tdata (m_axis),
    .i_tvalid(m_axis_valid),
    .o_tready(m_axis_ready),
    .o_tdata (s_axis),
    .o_tvalid(s_axis_valid),
    .i_tready(s_axis_ready)
  );

endmodule

// ==== rtl/noc_pkg.sv ====
`include "noc_settings.svh"

package noc_pkg;

  // Plain vectors with a meaning
  typedef logic [`NOC_DATA_W-1:0]              noc_word_t;
  typedef logic [`SAMP_W-1:0]                  sample_t;
  typedef logic [`HDR_SID_MSB-`HDR_SID_LSB:0]  sid_t;
  typedef logic [`HDR_LEN_MSB-`HDR_LEN_LSB:0]  pkt_len_t;
  typedef logic [`HDR_SEQ_MSB-`HDR_SEQ_LSB:0]  seqnum_t;
  typedef logic [`SET_ADDR_W-1:0]              set_addr_t;
  typedef logic [`SET_DATA_W-1:0]              set_data_t;

  // Packet type field of the header
  typedef enum logic [1:0] {
    DATA = 2'b00,
    FLOW = 2'b01,
    CMD  = 2'b10,
    RSVD = 2'b11
  } pkt_type_e;

  typedef struct packed {
    noc_word_t tdata;
    logic      tlast;
  } noc_stream_t;

  // Matches the {tlast, tdata} packing of the user FIFO
  typedef struct packed {
    logic    tlast;
    sample_t tdata;
  } samp_stream_t;

  typedef struct packed {
    logic      stb;
    set_addr_t addr;
    set_data_t data;
  } set_bus_t;

  typedef enum logic [1:0] {SH_HEADER, SH_PASS, SH_COMMAND, SH_DROP} shell_state_e;
  typedef enum logic [1:0] {DF_HEADER, DF_LOW, DF_HIGH} df_state_e;
  typedef enum logic [1:0] {RF_HEADER, RF_LOW, RF_HIGH} rf_state_e;

endpackage

// ==== rtl/noc_settings.svh ====
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Stream and sample widths
`define NOC_DATA_W 64
`define SAMP_W     32

// Settings bus
`define SET_ADDR_W  8
`define SET_DATA_W  32
`define SR_NEXT_DST 128

// FIFO depths as log2
`define USER_FIFO_LOG2 2
`define LEN_FIFO_LOG2  2

// Header word fields
`define HDR_TYPE_MSB 63
`define HDR_TYPE_LSB 62
`define HDR_SEQ_MSB  59
`define HDR_SEQ_LSB  48
`define HDR_LEN_MSB  47
`define HDR_LEN_LSB  32
`define HDR_SID_MSB  31
`define HDR_SID_LSB  0

// Command payload word fields
`define CMD_ADDR_MSB 39
`define CMD_ADDR_LSB 32
`define CMD_DATA_MSB 31
`define CMD_DATA_LSB 0

`endif

// ==== rtl/noc_shell.sv ====
`include "noc_settings.svh"

module noc_shell (
  input  logic                 ce_clk,
  input  logic                 i_rst,
  // Network input
  input  noc_pkg::noc_stream_t i_in,
  input  logic                 i_in_valid,
  output logic                 o_in_ready,
  // Stream sink toward the wrapper
  output noc_pkg::noc_stream_t o_sink,
  output logic                 o_sink_valid,
  input  logic                 i_sink_ready,
  // Stream source from the wrapper
  input  noc_pkg::noc_stream_t i_src,
  input  logic                 i_src_valid,
  output logic                 o_src_ready,
  // Network output
  output noc_pkg::noc_stream_t o_out,
  output logic                 o_out_valid,
  input  logic                 i_out_ready,
  // Settings bus
  output noc_pkg::set_bus_t    o_set
);

  noc_pkg::shell_state_e state;
  noc_pkg::pkt_type_e    in_type;
  logic                  in_xfer;
  logic                  set_stb_r;
  noc_pkg::set_addr_t    set_addr_r;
  noc_pkg::set_data_t    set_data_r;

  assign in_type = noc_pkg::pkt_type_e'(i_in.tdata[`HDR_TYPE_MSB:`HDR_TYPE_LSB]);

  //////////////////////////////
  // Input routing
  //////////////////////////////

  // Data words, header included, go straight to the sink
  assign o_sink = i_in;

  always_comb begin
    o_sink_valid = 1'b0;
    o_in_ready   = 1'b1;
    unique case (state)
      noc_pkg::SH_HEADER: begin
        if (in_type == noc_pkg::DATA) begin
          o_sink_valid = i_in_valid;
          o_in_ready   = i_sink_ready;
        end
      end
      noc_pkg::SH_PASS: begin
        o_sink_valid = i_in_valid;
        o_in_ready   = i_sink_ready;
      end
      // Command and drop states take a word every cycle
      default: o_in_ready = 1'b1;
    endcase
  end

  assign in_xfer = i_in_valid & o_in_ready;

  always_ff @(posedge ce_clk) begin
    if (i_rst) begin
      state     <= noc_pkg::SH_HEADER;
      set_stb_r <= 1'b0;
    end else begin
      set_stb_r <= (state == noc_pkg::SH_COMMAND) && in_xfer;
      if (in_xfer) begin
        if (state == noc_pkg::SH_HEADER) begin
          // Header-only packets leave the FSM where it is
          if (!i_in.tlast) begin
            unique case (in_type)
              noc_pkg::DATA: state <= noc_pkg::SH_PASS;
              noc_pkg::CMD:  state <= noc_pkg::SH_COMMAND;
              default:       state <= noc_pkg::SH_DROP;
            endcase
          end
        end else if (i_in.tlast) begin
          state <= noc_pkg::SH_HEADER;
        end
      end
    end
  end

  //////////////////////////////
  // Settings bus
  //////////////////////////////

  always_ff @(posedge ce_clk) begin
    if ((state == noc_pkg::SH_COMMAND) && in_xfer) begin
      set_addr_r <= i_in.tdata[`CMD_ADDR_MSB:`CMD_ADDR_LSB];
      set_data_r <= i_in.tdata[`CMD_DATA_MSB:`CMD_DATA_LSB];
    end
  end

  assign o_set = '{stb: set_stb_r, addr: set_addr_r, data: set_data_r};

  // Return path is untouched
  assign o_out       = i_src;
  assign o_out_valid = i_src_valid;
  assign o_src_ready = i_out_ready;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_noc_loopback -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_noc_loopback > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
fi
exit 1

// ==== tb/noc_loopback_sva.sv ====
module noc_loopback_sva (
  input logic                 ce_clk,
  input logic                 i_rst,
  input noc_pkg::noc_stream_t o_out,
  input logic                 o_out_valid,
  input logic                 i_out_ready,
  input logic                 set_stb
);

  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // No output word while reset is held
  out_idle_in_reset: assert property (@(posedge ce_clk) i_rst && $past(i_rst) |-> !o_out_valid)
    else begin
      fail_count++;
      $error("o_out_valid high during reset");
    end

  // Output word held until taken
  out_hold: assert property (@(posedge ce_clk) disable iff (i_rst)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out))
    else begin
      fail_count++;
      $error("output word changed or dropped before ready");
    end

  settings_strobe_pulse: assert property (@(posedge ce_clk) disable iff (i_rst)
    set_stb |=> !set_stb)
    else begin
      fail_count++;
      $error("settings strobe longer than one cycle");
    end

endmodule

bind noc_block_axi_fifo_loopback noc_loopback_sva sva0 (
  .ce_clk     (ce_clk),
  .i_rst      (i_rst),
  .o_out      (o_out),
  .o_out_valid(o_out_valid),
  .i_out_ready(i_out_ready),
  .set_stb    (set_bus.stb)
);

// ==== tb/tb_noc_loopback.sv ====
`include "noc_settings.svh"

module tb_noc_loopback;

  timeunit 1ns;
  timeprecision 1ps;

  // Run length in packets and the longest packet in words with its header
  localparam int NUM_PKTS        = 11;
  localparam int MAX_WORDS       = 17;
  localparam int WATCHDOG_CYCLES = NUM_PKTS * MAX_WORDS * 40 + 500;

  logic                 ce_clk;
  logic                 i_rst;
  noc_pkg::noc_stream_t i_in;
  logic                 i_in_valid;
  logic                 o_in_ready;
  noc_pkg::noc_stream_t o_out;
  logic                 o_out_valid;
  logic                 i_out_ready;

  noc_pkg::noc_stream_t tx_q[$];
  noc_pkg::noc_stream_t exp_q[$];
  noc_pkg::noc_stream_t rx_q[$];
  logic [31:0]          gap_state;
  logic [31:0]          rdy_state;
  logic [31:0]          data_state;
  noc_pkg::sid_t        exp_sid;
  noc_pkg::seqnum_t     exp_seq;
  int                   exp_pkts;
  int                   checks;
  int                   errors;

  noc_block_axi_fifo_loopback dut0 (
    .ce_clk     (ce_clk),
    .i_rst      (i_rst),
    .i_in       (i_in),
    .i_in_valid (i_in_valid),
    .o_in_ready (o_in_ready),
    .o_out      (o_out),
    .o_out_valid(o_out_valid),
    .i_out_ready(i_out_ready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #5 ce_clk = ~ce_clk;
  end

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic noc_pkg::noc_word_t make_header(input noc_pkg::pkt_type_e t,
                                                     input noc_pkg::seqnum_t seq,
                                                     input int nwords,
                                                     input noc_pkg::sid_t sid);
    noc_pkg::noc_word_t h;
    h = '0;
    h[`HDR_TYPE_MSB:`HDR_TYPE_LSB] = t;
    h[`HDR_SEQ_MSB:`HDR_SEQ_LSB]   = seq;
    // Length counts payload bytes
    h[`HDR_LEN_MSB:`HDR_LEN_LSB]   = noc_pkg::pkt_len_t'(nwords * 8);
    h[`HDR_SID_MSB:`HDR_SID_LSB]   = sid;
    return h;
  endfunction

  ////////////////////////////////
  // Packet queues and expected stream
  ////////////////////////////////

  task automatic add_data_packet(input int nwords);
    noc_pkg::noc_stream_t s;
    int                   i;
    s.tdata = make_header(noc_pkg::DATA, 12'h0, nwords, 32'h5A00_0000 + nwords);
    s.tlast = 1'b0;
    tx_q.push_back(s);
    // Reframed header carries the block's own stream ID and sequence number
    s.tdata = make_header(noc_pkg::DATA, exp_seq, nwords, exp_sid);
    exp_q.push_back(s);
    for (i = 0; i < nwords; i++) begin
      data_state         = lcg(data_state);
      s.tdata[31:0]      = data_state;
      data_state         = lcg(data_state);
      s.tdata[63:32]     = data_state;
      s.tlast            = (i == nwords - 1);
      tx_q.push_back(s);
      exp_q.push_back(s);
    end
    exp_seq++;
    exp_pkts++;
  endtask

  task automatic add_cmd_packet(input noc_pkg::set_addr_t addr, input noc_pkg::set_data_t data);
    noc_pkg::noc_stream_t s;
    s.tdata = make_header(noc_pkg::CMD, 12'h0, 1, 32'h0);
    s.tlast = 1'b0;
    tx_q.push_back(s);
    s.tdata = '0;
    s.tdata[`CMD_ADDR_MSB:`CMD_ADDR_LSB] = addr;
    s.tdata[`CMD_DATA_MSB:`CMD_DATA_LSB] = data;
    s.tlast = 1'b1;
    tx_q.push_back(s);
    if (addr == `SR_NEXT_DST) exp_sid = data;
  endtask

  task automatic add_drop_packet(input noc_pkg::pkt_type_e t, input int nwords);
    noc_pkg::noc_stream_t s;
    int                   i;
    s.tdata = make_header(t, 12'h0, nwords, 32'h0000_0F0F);
    s.tlast = 1'b0;
    tx_q.push_back(s);
    for (i = 0; i < nwords; i++) begin
      data_state = lcg(data_state);
      s.tdata    = {data_state, ~data_state};
      s.tlast    = (i == nwords - 1);
      tx_q.push_back(s);
    end
  endtask

  ////////////////////////////////
  // Driver and collector
  ////////////////////////////////

  // Starts and ends on a falling edge
  task automatic send_packet(input bit gaps);
    noc_pkg::noc_stream_t w;
    int                   gap;
    do begin
      w   = tx_q.pop_front();
      gap = 0;
      if (gaps) begin
        gap_state = lcg(gap_state);
        gap       = int'(gap_state[17:16]);
      end
      if (gap > 0) begin
        i_in_valid = 1'b0;
        repeat (gap) @(negedge ce_clk);
      end
      i_in       = w;
      i_in_valid = 1'b1;
      do begin
        @(posedge ce_clk);
      end while (!o_in_ready);
      @(negedge ce_clk);
    end while (!w.tlast);
    i_in_valid = 1'b0;
  endtask

  task automatic recv_packet(input bit rand_ready);
    bit   done;
    logic rdy;
    done = 1'b0;
    while (!done) begin
      @(negedge ce_clk);
      rdy = 1'b1;
      if (rand_ready) begin
        rdy_state = lcg(rdy_state);
        rdy       = rdy_state[20];
      end
      i_out_ready = rdy;
      @(posedge ce_clk);
      if (o_out_valid && i_out_ready) begin
        rx_q.push_back(o_out);
        done = o_out.tlast;
      end
    end
    @(negedge ce_clk);
    i_out_ready = 1'b0;
  endtask

  task automatic check_output;
    int i;
    checks++;
    if (rx_q.size() != exp_q.size()) begin
      errors++;
      $display("Error at %0t: received %0d words, expected %0d", $time,
               rx_q.size(), exp_q.size());
    end
    for (i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
      checks++;
      if (rx_q[i] !== exp_q[i]) begin
        errors++;
        $display("Error at %0t: word %0d is %h last %b, expected %h last %b", $time, i,
                 rx_q[i].tdata, rx_q[i].tlast, exp_q[i].tdata, exp_q[i].tlast);
      end
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic run_traffic(input bit gaps, input bit rand_ready);
    int npkts;
    npkts = exp_pkts;
    fork
      begin
        while (tx_q.size() > 0) send_packet(gaps);
      end
      begin
        repeat (npkts) recv_packet(rand_ready);
      end
    join
    check_output();
    exp_pkts = 0;
  endtask

  task automatic check_idle(input int cycles, input string what);
    bit seen;
    seen = 1'b0;
    repeat (cycles) begin
      @(posedge ce_clk);
      if (o_out_valid) seen = 1'b1;
    end
    checks++;
    if (seen) begin
      errors++;
      $display("Error at %0t: unexpected output word %s", $time, what);
    end
    @(negedge ce_clk);
  endtask

  ////////////////////////////////
  // Directed tests
  ////////////////////////////////

  task automatic test_cmd_then_data;
    add_cmd_packet(8'd128, 32'hC0DE_0042);
    add_data_packet(4);
    run_traffic(1'b0, 1'b0);
  endtask

  task automatic test_back_to_back;
    add_data_packet(1);
    add_data_packet(5);
    add_data_packet(3);
    run_traffic(1'b0, 1'b0);
  endtask

  task automatic test_backpressure;
    add_data_packet(16);
    run_traffic(1'b1, 1'b1);
  endtask

  task automatic test_dropped_types;
    add_drop_packet(noc_pkg::FLOW, 2);
    add_drop_packet(noc_pkg::RSVD, 1);
    while (tx_q.size() > 0) send_packet(1'b0);
    check_idle(30, "after flow-control and reserved packets");
    add_data_packet(2);
    run_traffic(1'b0, 1'b0);
  endtask

  task automatic test_other_address;
    add_cmd_packet(8'd64, 32'hDEAD_BEEF);
    add_data_packet(3);
    run_traffic(1'b1, 1'b0);
  endtask

  initial begin
    i_rst       = 1'b1;
    i_in        = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b0;
    gap_state   = 32'h9006;
    rdy_state   = lcg(32'h9006);
    data_state  = lcg(rdy_state);
    exp_sid     = '0;
    exp_seq     = '0;
    exp_pkts    = 0;
    checks      = 0;
    errors      = 0;
    repeat (16) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst = 1'b0;
    check_idle(50, "after reset");
    test_cmd_then_data();
    test_back_to_back();
    test_backpressure();
    test_dropped_types();
    test_other_address();
    repeat (10) @(posedge ce_clk);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut0.sva0.fail_count);
    if (errors == 0 && dut0.sva0.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ce_clk);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
